// ==== src/cpu_pkg.sv ====
// Instruction-set definitions shared by the core, the ALU and the testbench program builder
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_addr_t;

  // Codes 8 to 15 are decoded as halt
  typedef enum logic [3:0] {
    op_and  = 4'd0,
    op_or   = 4'd1,
    op_sub  = 4'd2,
    op_add  = 4'd3,
    op_ldr  = 4'd4,
    op_str  = 4'd5,
    op_b    = 4'd6,
    op_halt = 4'd7
  } opcode_e;

  typedef enum logic [1:0] {alu_and, alu_or, alu_sub, alu_add} alu_op_e;

  typedef enum logic [2:0] {idle, fetch, execute, mem_access, halted} core_state_e;

  localparam int OPC_HI   = 31;
  localparam int OPC_LO   = 28;
  localparam int RD_HI    = 27;
  localparam int RD_LO    = 24;
  localparam int RN_HI    = 23;
  localparam int RN_LO    = 20;
  localparam int IMM_BIT  = 19; // Selects rotated immediate over rm
  localparam int RM_HI    = 15;
  localparam int RM_LO    = 12;
  localparam int IMM12_HI = 11;
  localparam int IMM12_LO = 0;

endpackage

`default_nettype wire

// ==== src/bus_pkg.sv ====
// Memory and bus sizes shared by the host port, the arbiter and the core
`default_nettype none

package bus_pkg;

  localparam int ADDR_W    = 8;  // Byte address bits
  localparam int MEM_WORDS = 64; // 256 bytes of shared memory

  typedef logic [ADDR_W-1:0] byte_addr_t;

endpackage

`default_nettype wire

// ==== src/mem_req_if.sv ====
// Word access from one requester to the shared memory, held until a one-cycle ready
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if;

  logic                valid;
  logic                write;
  bus_pkg::byte_addr_t addr;  // Low two bits ignored
  cpu_pkg::word_t      wdata;
  logic                ready; // One-cycle pulse per access
  cpu_pkg::word_t      rdata; // Valid in the ready cycle

  modport requester (output valid, write, addr, wdata, input ready, rdata);
  modport memory (input valid, write, addr, wdata, output ready, rdata);

endinterface

`default_nettype wire

// ==== src/axil_host_port.sv ====
// AXI4-Lite slave that turns one host read or write at a time into a shared memory request
`timescale 1ns/100ps
`default_nettype none

module axil_host_port #(
  parameter int MEM_WORDS = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  bus_pkg::byte_addr_t awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  cpu_pkg::word_t      wdata,
  input  logic                wvalid,
  output logic                wready,
  output logic                bvalid,
  input  logic                bready,
  input  bus_pkg::byte_addr_t araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic                rvalid,
  output cpu_pkg::word_t      rdata,
  input  logic                rready,
  mem_req_if.requester        mem
);

  typedef enum logic [2:0] {hp_idle, hp_wr, hp_rd, hp_bresp, hp_rresp} host_state_e;

  localparam bus_pkg::byte_addr_t ADDR_MASK = bus_pkg::byte_addr_t'(MEM_WORDS * 4 - 1);

  host_state_e         state;
  bus_pkg::byte_addr_t addr_q;
  cpu_pkg::word_t      wdata_q;
  cpu_pkg::word_t      rdata_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= hp_idle;
    end else begin
      case (state)
        hp_idle:  if (arvalid) state <= hp_rd; // Reads win a tie
                  else if (awvalid && wvalid) state <= hp_wr;
        hp_wr:    if (mem.ready) state <= hp_bresp;
        hp_rd:    if (mem.ready) state <= hp_rresp;
        hp_bresp: if (bready) state <= hp_idle;
        hp_rresp: if (rready) state <= hp_idle;
        default:  state <= hp_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == hp_idle) begin
      addr_q  <= arvalid ? araddr : awaddr;
      wdata_q <= wdata;
    end
    if (state == hp_rd && mem.ready) begin
      rdata_q <= mem.rdata; // Held until the host takes it
    end
  end

  assign mem.valid = (state == hp_wr) || (state == hp_rd);
  assign mem.write = (state == hp_wr);
  assign mem.addr  = addr_q & ADDR_MASK;
  assign mem.wdata = wdata_q;

  assign awready = (state == hp_wr) && mem.ready;
  assign wready  = (state == hp_wr) && mem.ready;
  assign arready = (state == hp_rd) && mem.ready;
  assign bvalid  = (state == hp_bresp);
  assign rvalid  = (state == hp_rresp);
  assign rdata   = rdata_q;

endmodule

`default_nettype wire

// ==== src/shared_mem.sv ====
// Word memory shared by the host port and the core, with a fixed-priority arbiter in front
`timescale 1ns/100ps
`default_nettype none

module shared_mem #(
  parameter int MEM_WORDS = 64
) (
  input  logic      clk,
  input  logic      reset,
  mem_req_if.memory host,
  mem_req_if.memory core
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  cpu_pkg::word_t      mem_array [MEM_WORDS];
  cpu_pkg::word_t      rdata_q;
  logic                gnt_host;
  logic                gnt_core;
  logic                host_rdy_q;
  logic                core_rdy_q;
  logic                sel_write;
  bus_pkg::byte_addr_t sel_addr;
  cpu_pkg::word_t      sel_wdata;
  logic [IDX_W-1:0]    sel_idx;

  // A requester still shows valid in its ready cycle, so it is masked there
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      gnt_host   <= 1'b0;
      gnt_core   <= 1'b0;
      host_rdy_q <= 1'b0;
      core_rdy_q <= 1'b0;
    end else begin
      host_rdy_q <= gnt_host;
      core_rdy_q <= gnt_core;
      if (gnt_host || gnt_core) begin
        gnt_host <= 1'b0;
        gnt_core <= 1'b0;
      end else if (host.valid && !host_rdy_q) begin
        gnt_host <= 1'b1; // Host first
      end else if (core.valid && !core_rdy_q) begin
        gnt_core <= 1'b1;
      end
    end
  end

  assign sel_write = gnt_host ? host.write : core.write;
  assign sel_addr  = gnt_host ? host.addr : core.addr;
  assign sel_wdata = gnt_host ? host.wdata : core.wdata;
  assign sel_idx   = sel_addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (gnt_host || gnt_core) begin
      if (sel_write) mem_array[sel_idx] <= sel_wdata;
      rdata_q <= mem_array[sel_idx];
    end
  end

  assign host.ready = host_rdy_q;
  assign core.ready = core_rdy_q;
  assign host.rdata = rdata_q;
  assign core.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// Sixteen 32-bit core registers with two combinational read ports and one clocked write port
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic               clk,
  input  cpu_pkg::reg_addr_t ra_addr,
  input  cpu_pkg::reg_addr_t rb_addr,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  logic               wr_en,
  input  cpu_pkg::word_t     wr_data,
  output cpu_pkg::word_t     ra_data,
  output cpu_pkg::word_t     rb_data
);

  cpu_pkg::word_t regs [16];

  always_ff @(posedge clk) begin
    if (wr_en) regs[wr_addr] <= wr_data;
  end

  assign ra_data = regs[ra_addr];
  assign rb_data = regs[rb_addr]; // Also reads rd for stores

endmodule

`default_nettype wire

// ==== src/alu.sv ====
// Operand B select with rotated immediate, then AND, OR, SUB or ADD on 32-bit words
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   reg_b,
  input  logic             imm_sel,
  input  logic [11:0]      imm12,
  output cpu_pkg::word_t   result
);

  cpu_pkg::word_t imm_ext;
  logic [4:0]     rot_amt;
  logic [63:0]    rot_pair;
  cpu_pkg::word_t b;

  assign imm_ext  = {24'd0, imm12[7:0]};
  assign rot_amt  = {imm12[11:8], 1'b0};         // Twice the 4-bit field
  assign rot_pair = {imm_ext, imm_ext} >> rot_amt; // Rotate right via doubled word
  assign b        = imm_sel ? rot_pair[31:0] : reg_b;

  always_comb begin
    case (op)
      cpu_pkg::alu_and: result = a & b;
      cpu_pkg::alu_or:  result = a | b;
      cpu_pkg::alu_sub: result = a - b; // Wraps modulo 2^32
      default:          result = a + b;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/core_ctrl.sv ====
// Multicycle core sequencer holding the PC and instruction register, driving fetch and data access
`timescale 1ns/100ps
`default_nettype none

module core_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  output logic                busy,
  output logic                halted,
  mem_req_if.requester        mem,
  output cpu_pkg::reg_addr_t  rn_addr,
  output cpu_pkg::reg_addr_t  rm_addr,
  output cpu_pkg::reg_addr_t  rd_addr,
  input  cpu_pkg::word_t      rn_data,
  input  cpu_pkg::word_t      rm_data,
  output logic                wr_en,
  output cpu_pkg::word_t      wr_data,
  output cpu_pkg::alu_op_e    alu_op,
  output logic                imm_sel,
  output logic [11:0]         imm12,
  input  cpu_pkg::word_t      alu_result
);

  cpu_pkg::core_state_e state;
  bus_pkg::byte_addr_t  pc;
  cpu_pkg::word_t       ir;
  cpu_pkg::opcode_e     opcode;
  logic                 is_alu;
  cpu_pkg::word_t       data_addr;
  cpu_pkg::word_t       br_off;

  assign opcode    = cpu_pkg::opcode_e'(ir[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO]);
  assign data_addr = rn_data + cpu_pkg::word_t'(ir[cpu_pkg::IMM12_HI:cpu_pkg::IMM12_LO]);
  assign br_off    = {{22{ir[7]}}, ir[7:0], 2'b00}; // Signed word offset

  always_comb begin
    is_alu = 1'b1;
    case (opcode)
      cpu_pkg::op_and: alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_or:  alu_op = cpu_pkg::alu_or;
      cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_add: alu_op = cpu_pkg::alu_add;
      default: begin
        is_alu = 1'b0;
        alu_op = cpu_pkg::alu_add;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= cpu_pkg::idle;
      pc    <= '0;
    end else begin
      case (state)
        cpu_pkg::idle, cpu_pkg::halted: begin
          if (start) begin
            pc    <= '0;
            state <= cpu_pkg::fetch;
          end
        end
        cpu_pkg::fetch: begin
          if (mem.ready) begin
            pc    <= pc + 8'd4;
            state <= cpu_pkg::execute;
          end
        end
        cpu_pkg::execute: begin
          if (is_alu) state <= cpu_pkg::fetch;
          else if (opcode == cpu_pkg::op_ldr || opcode == cpu_pkg::op_str)
            state <= cpu_pkg::mem_access;
          else if (opcode == cpu_pkg::op_b) begin
            pc    <= pc + br_off[bus_pkg::ADDR_W-1:0]; // PC already points past the branch
            state <= cpu_pkg::fetch;
          end else state <= cpu_pkg::halted; // op_halt and unused codes
        end
        cpu_pkg::mem_access: if (mem.ready) state <= cpu_pkg::fetch;
        default: state <= cpu_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cpu_pkg::fetch && mem.ready) ir <= mem.rdata;
  end

  assign mem.valid = (state == cpu_pkg::fetch) || (state == cpu_pkg::mem_access);
  assign mem.write = (state == cpu_pkg::mem_access) && (opcode == cpu_pkg::op_str);
  assign mem.addr  = (state == cpu_pkg::fetch) ? pc : data_addr[bus_pkg::ADDR_W-1:0];
  assign mem.wdata = rm_data; // rd value during a store

  assign rn_addr = ir[cpu_pkg::RN_HI:cpu_pkg::RN_LO];
  assign rd_addr = ir[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
  assign rm_addr = (state == cpu_pkg::mem_access) ? ir[cpu_pkg::RD_HI:cpu_pkg::RD_LO]
                                                  : ir[cpu_pkg::RM_HI:cpu_pkg::RM_LO];
  assign imm_sel = ir[cpu_pkg::IMM_BIT];
  assign imm12   = ir[cpu_pkg::IMM12_HI:cpu_pkg::IMM12_LO];

  assign wr_en   = ((state == cpu_pkg::execute) && is_alu) ||
                   ((state == cpu_pkg::mem_access) && (opcode == cpu_pkg::op_ldr) && mem.ready);
  assign wr_data = (state == cpu_pkg::mem_access) ? mem.rdata : alu_result;

  assign busy   = (state == cpu_pkg::fetch) || (state == cpu_pkg::execute) ||
                  (state == cpu_pkg::mem_access);
  assign halted = (state == cpu_pkg::halted);

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
// Processor top level with an AXI4-Lite host port into shared memory and start/busy/halted control
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
  parameter int MEM_WORDS = bus_pkg::MEM_WORDS
) (
  input  logic                clk,
  input  logic                reset,
  input  bus_pkg::byte_addr_t awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  cpu_pkg::word_t      wdata,
  input  logic                wvalid,
  output logic                wready,
  output logic                bvalid,
  input  logic                bready,
  input  bus_pkg::byte_addr_t araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic                rvalid,
  output cpu_pkg::word_t      rdata,
  input  logic                rready,
  input  logic                start,
  output logic                busy,
  output logic                halted
);

  cpu_pkg::reg_addr_t rn_addr;
  cpu_pkg::reg_addr_t rm_addr;
  cpu_pkg::reg_addr_t rd_addr;
  cpu_pkg::word_t     rn_data;
  cpu_pkg::word_t     rm_data;
  logic               wr_en;
  cpu_pkg::word_t     wr_data;
  cpu_pkg::alu_op_e   alu_op;
  logic               imm_sel;
  logic [11:0]        imm12;
  cpu_pkg::word_t     alu_result;

  mem_req_if host_req ();
  mem_req_if core_req ();

  axil_host_port #(.MEM_WORDS(MEM_WORDS)) u_host (
    .clk, .reset, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bvalid, .bready, .araddr, .arvalid, .arready, .rvalid, .rdata, .rready,
    .mem(host_req.requester)
  );

  shared_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk, .reset, .host(host_req.memory), .core(core_req.memory)
  );

  core_ctrl u_ctrl (
    .clk, .reset, .start, .busy, .halted, .mem(core_req.requester),
    .rn_addr, .rm_addr, .rd_addr, .rn_data, .rm_data, .wr_en, .wr_data,
    .alu_op, .imm_sel, .imm12, .alu_result
  );

  reg_file u_regs (
    .clk, .ra_addr(rn_addr), .rb_addr(rm_addr), .wr_addr(rd_addr), .wr_en, .wr_data,
    .ra_data(rn_data), .rb_data(rm_data)
  );

  alu u_alu (
    .op(alu_op), .a(rn_data), .reg_b(rm_data), .imm_sel, .imm12, .result(alu_result)
  );

endmodule

`default_nettype wire

// ==== test/cpu_props.sv ====
// Concurrent checks on the cpu_top host responses and run-control outputs, bound into the DUT
`timescale 1ns/100ps
`default_nettype none

module cpu_props (
  input logic           clk,
  input logic           reset,
  input logic           bvalid,
  input logic           bready,
  input logic           rvalid,
  input logic           rready,
  input cpu_pkg::word_t rdata,
  input logic           busy,
  input logic           halted
);

  int unsigned fail_count = 0; // Failed assertions so far

  bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  rvalid_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // Read data frozen while the host stalls
  rdata_stable: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> $stable(rdata))
    else begin
      fail_count++;
      $error("rdata changed while rvalid waited for rready");
    end

  run_state_excl: assert property (@(posedge clk) disable iff (reset)
    !(busy && halted))
    else begin
      fail_count++;
      $error("busy and halted both high");
    end

endmodule

`default_nettype wire

// ==== test/tb_cpu.sv ====
// Directed testbench for cpu_top that loads programs over AXI4-Lite, runs the core, checks results
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

  localparam int             TIMEOUT   = 4000; // Cycles allowed per wait loop
  localparam cpu_pkg::word_t HALT_WORD = 32'h7000_0000;
  localparam cpu_pkg::word_t SENTINEL  = 32'h5A5A_A5A5;

  logic                clk;
  logic                reset;
  bus_pkg::byte_addr_t awaddr;
  bus_pkg::byte_addr_t araddr;
  cpu_pkg::word_t      wdata;
  cpu_pkg::word_t      rdata;
  logic                awvalid, wvalid, bready, arvalid, rready, start;
  logic                awready, wready, bvalid, arready, rvalid, busy, halted;
  cpu_pkg::word_t      prog [$];

  cpu_top u_dut (.*);

  bind cpu_top cpu_props u_props (
    .clk(clk), .reset(reset), .bvalid(bvalid), .bready(bready), .rvalid(rvalid),
    .rready(rready), .rdata(rdata), .busy(busy), .halted(halted)
  );

  always #10 clk = ~clk; // 20 ns period

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "%s", msg);
  endtask

  task automatic check(input string name, input cpu_pkg::word_t got,
                       input cpu_pkg::word_t exp);
    if (got !== exp) abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  function automatic cpu_pkg::word_t enc(input logic [3:0] opc, input logic [3:0] rd,
      input logic [3:0] rn, input logic imm, input logic [3:0] rm, input logic [11:0] imm12);
    return {opc, rd, rn, imm, 3'b000, rm, imm12};
  endfunction

  function automatic cpu_pkg::word_t rr(input logic [3:0] opc, input logic [3:0] rd,
      input logic [3:0] rn, input logic [3:0] rm);
    return enc(opc, rd, rn, 1'b0, rm, 12'd0);
  endfunction

  function automatic cpu_pkg::word_t ri(input logic [3:0] opc, input logic [3:0] rd,
      input logic [3:0] rn, input logic [3:0] rot, input logic [7:0] imm8);
    return enc(opc, rd, rn, 1'b1, 4'd0, {rot, imm8});
  endfunction

  function automatic cpu_pkg::word_t mem_op(input logic [3:0] opc, input logic [3:0] rd,
      input logic [3:0] rn, input logic [11:0] off);
    return enc(opc, rd, rn, 1'b0, 4'd0, off);
  endfunction

  // Rotates right one bit per step
  function automatic cpu_pkg::word_t rot_imm(input logic [3:0] rot, input logic [7:0] imm8);
    cpu_pkg::word_t v;
    v = {24'd0, imm8};
    repeat (2 * rot) v = {v[0], v[31:1]};
    return v;
  endfunction

  task automatic axi_write(input bus_pkg::byte_addr_t addr, input cpu_pkg::word_t data,
                           input int delay);
    int n;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("timed out waiting for awready");
    end while (!awready);
    check("wready", {31'd0, wready}, 32'd1);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("timed out waiting for bvalid");
    end while (!bvalid);
    repeat (delay) begin
      @(negedge clk);
      check("bvalid", {31'd0, bvalid}, 32'd1);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input bus_pkg::byte_addr_t addr, input int delay,
                          output cpu_pkg::word_t data);
    int n;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("timed out waiting for arready");
    end while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("timed out waiting for rvalid");
    end while (!rvalid);
    data = rdata;
    repeat (delay) begin
      @(negedge clk);
      check("rvalid", {31'd0, rvalid}, 32'd1);
      check("rdata", rdata, data);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic load_program(input int max_delay);
    foreach (prog[i]) axi_write(bus_pkg::byte_addr_t'(4 * i), prog[i], $urandom_range(max_delay));
  endtask

  task automatic start_core;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check("busy", {31'd0, busy}, 32'd1);
    check("halted", {31'd0, halted}, 32'd0);
  endtask

  task automatic wait_halted;
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_run("timed out waiting for the core to halt");
    end while (!halted);
    check("busy", {31'd0, busy}, 32'd0);
  endtask

  task automatic run_program;
    start_core();
    wait_halted();
  endtask

  task automatic build_ldst_prog;
    prog.delete();
    prog.push_back(ri(cpu_pkg::op_and, 0, 0, 4'd0, 8'd0));   // r0 = 0 whatever it held
    prog.push_back(ri(cpu_pkg::op_add, 1, 0, 4'd0, 8'h90));  // Base register
    prog.push_back(mem_op(cpu_pkg::op_ldr, 2, 1, 12'h010));
    prog.push_back(mem_op(cpu_pkg::op_ldr, 3, 1, 12'h014));
    prog.push_back(rr(cpu_pkg::op_add, 4, 2, 3));
    prog.push_back(mem_op(cpu_pkg::op_str, 4, 1, 12'h020));
    prog.push_back(mem_op(cpu_pkg::op_str, 2, 1, 12'h024));
    prog.push_back(HALT_WORD);
  endtask

  // Loop rewrites its own branch so the opcode carries from b into halt after count passes
  task automatic build_loop_prog(input int count);
    prog.delete();
    prog.push_back(ri(cpu_pkg::op_and, 0, 0, 4'd0, 8'd0));
    prog.push_back(ri(cpu_pkg::op_add, 1, 0, 4'd0, 8'(count)));  // Down counter
    prog.push_back(ri(cpu_pkg::op_add, 2, 0, 4'd0, 8'd0));       // Iteration count
    prog.push_back(ri(cpu_pkg::op_add, 3, 0, 4'd0, 8'h7B));
    prog.push_back({4'h6, 20'd0, 8'd1});                         // Skip the next store
    prog.push_back(mem_op(cpu_pkg::op_str, 3, 0, 12'h0C0));
    prog.push_back(mem_op(cpu_pkg::op_ldr, 5, 0, 12'h034));      // Fetch branch word
    prog.push_back(ri(cpu_pkg::op_sub, 1, 1, 4'd0, 8'd1));       // Loop top at 0x1C
    prog.push_back(ri(cpu_pkg::op_add, 2, 2, 4'd0, 8'd1));
    prog.push_back(mem_op(cpu_pkg::op_str, 2, 0, 12'h0C4));
    prog.push_back(mem_op(cpu_pkg::op_str, 1, 0, 12'h0C8));
    prog.push_back(ri(cpu_pkg::op_add, 5, 5, 4'd4, 8'd1));       // Plus 1 << 24
    prog.push_back(mem_op(cpu_pkg::op_str, 5, 0, 12'h034));
    prog.push_back(32'h7000_00F9 - (cpu_pkg::word_t'(count) << 24)); // b -7 at 0x34
  endtask

  task automatic test_mem_rw;
    bus_pkg::byte_addr_t a;
    cpu_pkg::word_t      v;
    cpu_pkg::word_t      model [64];
    bus_pkg::byte_addr_t addrs [$];
    repeat (12) begin
      a = bus_pkg::byte_addr_t'($urandom) & 8'hFC;
      v = $urandom;
      axi_write(a, v, 0);
      model[a[7:2]] = v;
      addrs.push_back(a);
    end
    foreach (addrs[i]) begin
      axi_read(addrs[i], 0, v);
      check("rdata", v, model[addrs[i][7:2]]);
    end
  endtask

  task automatic test_alu;
    logic [7:0]     ia;
    logic [7:0]     ib;
    logic [3:0]     ra;
    cpu_pkg::word_t x1;
    cpu_pkg::word_t x2;
    cpu_pkg::word_t got;
    cpu_pkg::word_t exp [8];
    int             k;
    ia = 8'($urandom) | 8'h80;
    ib = 8'($urandom);
    ra = 4'($urandom);
    x1 = rot_imm(ra, ia);
    x2 = rot_imm(4'd0, ib);
    exp[0] = x1 + x2;
    exp[1] = x2 - x1;
    exp[2] = x1 & rot_imm(4'd1, 8'hFF);
    exp[3] = x1 | x2;
    exp[4] = 32'd0 - 32'd1;                  // Wraps to all ones
    exp[5] = x1 + rot_imm(4'd15, 8'h81);
    exp[6] = x1 & x2;
    exp[7] = x2 | rot_imm(4'd4, 8'hA5);
    prog.delete();
    prog.push_back(ri(cpu_pkg::op_and, 0, 0, 4'd0, 8'd0));
    prog.push_back(ri(cpu_pkg::op_add, 1, 0, ra, ia));
    prog.push_back(ri(cpu_pkg::op_add, 2, 0, 4'd0, ib));
    prog.push_back(rr(cpu_pkg::op_add, 3, 1, 2));
    prog.push_back(rr(cpu_pkg::op_sub, 4, 2, 1));
    prog.push_back(ri(cpu_pkg::op_and, 5, 1, 4'd1, 8'hFF));
    prog.push_back(rr(cpu_pkg::op_or, 6, 2, 1));
    prog.push_back(ri(cpu_pkg::op_sub, 7, 0, 4'd0, 8'd1));
    prog.push_back(ri(cpu_pkg::op_add, 8, 1, 4'd15, 8'h81));
    prog.push_back(rr(cpu_pkg::op_and, 9, 1, 2));
    prog.push_back(ri(cpu_pkg::op_or, 10, 2, 4'd4, 8'hA5));
    for (k = 0; k < 8; k++) begin
      prog.push_back(mem_op(cpu_pkg::op_str, 4'(3 + k), 0, 12'h080 + 12'(4 * k)));
    end
    prog.push_back(HALT_WORD);
    load_program(0);
    run_program();
    for (k = 0; k < 8; k++) begin
      axi_read(8'h80 + 8'(4 * k), 0, got);
      check($sformatf("alu result %0d", k), got, exp[k]);
    end
  endtask

  task automatic check_ldst(input cpu_pkg::word_t d0, input cpu_pkg::word_t d1,
                            input int max_delay);
    cpu_pkg::word_t got;
    axi_read(8'hB0, $urandom_range(max_delay), got);
    check("ldr sum", got, d0 + d1);
    axi_read(8'hB4, $urandom_range(max_delay), got);
    check("ldr copy", got, d0);
  endtask

  task automatic test_ldr_str;
    cpu_pkg::word_t d0;
    cpu_pkg::word_t d1;
    d0 = $urandom;
    d1 = $urandom;
    axi_write(8'hA0, d0, 0);
    axi_write(8'hA4, d1, 0);
    build_ldst_prog();
    load_program(0);
    run_program();
    check_ldst(d0, d1, 0);
  endtask

  task automatic test_branch;
    cpu_pkg::word_t got;
    axi_write(8'hC0, SENTINEL, 0);
    axi_write(8'hC4, SENTINEL, 0);
    axi_write(8'hC8, SENTINEL, 0);
    build_loop_prog(4);
    load_program(0);
    run_program();
    axi_read(8'hC0, 0, got);
    check("skipped store", got, SENTINEL);
    axi_read(8'hC4, 0, got);
    check("iterations", got, 32'd4);
    axi_read(8'hC8, 0, got);
    check("down counter", got, 32'd0);
    axi_read(8'h34, 0, got);
    check("rewritten branch", got, 32'h7000_00F9);
  endtask

  task automatic test_concurrent;
    cpu_pkg::word_t v;
    cpu_pkg::word_t got;
    v = $urandom;
    axi_write(8'hD0, v, 0);
    axi_write(8'hC4, SENTINEL, 0);
    axi_write(8'hC8, SENTINEL, 0);
    build_loop_prog(16);
    load_program(0);
    start_core();
    repeat (4) begin
      axi_read(8'hD0, 0, got);
      check("untouched word", got, v);
    end
    @(negedge clk);
    check("busy", {31'd0, busy}, 32'd1);  // Loop still going
    wait_halted();
    axi_read(8'hC4, 0, got);
    check("iterations", got, 32'd16);
    axi_read(8'hC8, 0, got);
    check("down counter", got, 32'd0);
  endtask

  task automatic test_backpressure;
    cpu_pkg::word_t d0;
    cpu_pkg::word_t d1;
    d0 = $urandom;
    d1 = $urandom;
    build_ldst_prog();
    load_program(7);
    axi_write(8'hA0, d0, $urandom_range(7));
    axi_write(8'hA4, d1, $urandom_range(7));
    run_program();
    check_ldst(d0, d1, 7);
    axi_write(8'hB0, 32'd0, $urandom_range(7));
    axi_write(8'hB4, 32'd0, $urandom_range(7));
    run_program();  // Second start from halted
    check_ldst(d0, d1, 7);
  endtask

  initial begin
    void'($urandom(55434));
    clk     = 1'b0;
    reset   = 1'b1;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    start   = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    check("awready wready arready bvalid rvalid busy halted",
          {25'd0, awready, wready, arready, bvalid, rvalid, busy, halted}, 32'd0);
    check("core state", 32'(u_dut.u_ctrl.state), 32'(cpu_pkg::idle));
    @(posedge clk);
    reset <= 1'b0;
    test_mem_rw();
    test_alu();
    test_ldr_str();
    test_branch();
    test_concurrent();
    test_backpressure();
    if (u_dut.u_props.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("concurrent assertion failures during the run");
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/cpu_pkg.sv
src/bus_pkg.sv
src/mem_req_if.sv
src/axil_host_port.sv
src/shared_mem.sv
src/reg_file.sv
src/alu.sv
src/core_ctrl.sv
src/cpu_top.sv
test/cpu_props.sv
test/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_cpu \
  -f filelist.f -Mdir obj_dir -o sim
status=0
./obj_dir/sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "STATUS: FAIL" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
grep -q "STATUS: PASS" sim.log
